// File: Makefile
# Verilator build and run of the piano tone path testbench

VERILATOR ?= verilator
TOP       ?= piano_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= piano.f
VFLAGS    ?= --binary --timing --assert

SRCS := piano_params.svh $(wildcard source/*.sv) $(wildcard verification/*.sv) \
        $(wildcard verification/*.svh)

SIM := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: piano.f
+incdir+.
+incdir+verification
source/piano_pkg.sv
source/spi_note_receiver.sv
source/note_envelope.sv
source/voice_mixer.sv
source/dac_serializer.sv
source/piano.sv
verification/piano_tb.sv

// File: piano_params.svh
// ***************************************************************************
// widths, sync word and timing constants of the three-voice piano tone path
// include wherever one of these values is needed
// ***************************************************************************

`ifndef PIANO_PARAMS_SVH
`define PIANO_PARAMS_SVH

`define NOTE_W            8
`define COUNT_W           2
`define FRAME_W           32
`define SYNC_WORD         32'h0000FFFF    // arms the spi receiver

`define ENV_SEGS          16
`define ENV_SEG_CYCLES    64              // clk cycles per envelope segment

`define DAC_BIT_CYCLES    8
`define DAC_FRAME_CYCLES  96              // data, load and ldac phases

`endif

// File: source/dac_serializer.sv
// ***************************************************************************
// serial dac driver, one 8-bit sample per frame of DAC_FRAME_CYCLES clocks
// msb first on data, then a load pulse and an ldac pulse
// ***************************************************************************
`timescale 1ns/1ns
`include "piano_params.svh"

module dac_serializer
(
    input  logic             clk,
    input  logic             rst_n,
    input  piano_pkg::note_t sample,
    output logic             dclk,
    output logic             data,
    output logic             load,
    output logic             ldac
);
    localparam int DATA_CYCLES = `NOTE_W * `DAC_BIT_CYCLES;
    localparam int LOAD_START  = DATA_CYCLES + `DAC_BIT_CYCLES;
    localparam int LOAD_END    = LOAD_START + `DAC_BIT_CYCLES;
    localparam int LDAC_START  = LOAD_END + `DAC_BIT_CYCLES / 2;
    localparam int LDAC_END    = LDAC_START + `DAC_BIT_CYCLES;
    localparam int CNT_W       = $clog2(`DAC_FRAME_CYCLES);

    logic [CNT_W-1:0] frame_cnt;
    logic [CNT_W-1:0] phase;
    logic             in_data;
    logic             bit_start;
    piano_pkg::note_t sreg;

    assign phase     = CNT_W'(frame_cnt % `DAC_BIT_CYCLES);
    assign in_data   = frame_cnt < DATA_CYCLES;
    assign bit_start = phase == '0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            frame_cnt <= '0;
        else if (frame_cnt == CNT_W'(`DAC_FRAME_CYCLES - 1))
            frame_cnt <= '0;
        else
            frame_cnt <= frame_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (frame_cnt == '0)
            sreg <= {sample[`NOTE_W-2:0], 1'b0};   // msb goes straight to data
        else if (in_data && bit_start)
            sreg <= sreg << 1;
    end

    // pins are registered, so they trail frame_cnt by one clock
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dclk <= 1'b0;
            data <= 1'b0;
            load <= 1'b1;
            ldac <= 1'b1;
        end
        else
        begin
            dclk <= in_data && (phase < `DAC_BIT_CYCLES / 2);
            load <= !(frame_cnt >= LOAD_START && frame_cnt < LOAD_END);
            ldac <= !(frame_cnt >= LDAC_START && frame_cnt < LDAC_END);
            if (frame_cnt == '0)
                data <= sample[`NOTE_W-1];
            else if (!in_data)
                data <= 1'b0;
            else if (bit_start)
                data <= sreg[`NOTE_W-1];  // stable through the falling dclk
        end
    end

    a_strobes_apart: assert property (@(posedge clk) disable iff (!rst_n)
        load || ldac);

endmodule

// File: source/note_envelope.sv
// ***************************************************************************
// envelope of one voice, rise, peak, decay and silence in 16 gain segments
// a nonzero note starts it, a zero note clears it
// ***************************************************************************
`timescale 1ns/1ns
`include "piano_params.svh"

module note_envelope
(
    input  logic             clk,
    input  logic             rst_n,
    input  piano_pkg::note_t note,
    output piano_pkg::note_t attenuated,
    output logic             running,
    output logic             done
);
    localparam int LIMIT  = `ENV_SEGS * `ENV_SEG_CYCLES;
    localparam int CNT_W  = $clog2(LIMIT + 1);
    localparam int SEG_W  = $clog2(`ENV_SEGS) + 1;
    localparam int GAIN_W = 8;

    logic [CNT_W-1:0]          cnt;
    logic [SEG_W-1:0]          seg;
    logic [GAIN_W-1:0]         gain;
    logic [`NOTE_W+GAIN_W-1:0] product;

    assign seg     = SEG_W'(cnt / `ENV_SEG_CYCLES);
    assign product = note * gain;

    always_comb
    begin
        case (seg)
            5'd0:    gain = 8'd64;    // attack
            5'd1:    gain = 8'd128;
            5'd2:    gain = 8'd192;
            5'd3:    gain = 8'd255;   // peak
            5'd4:    gain = 8'd224;
            5'd5:    gain = 8'd208;
            5'd6:    gain = 8'd192;
            5'd7:    gain = 8'd176;
            5'd8:    gain = 8'd160;
            5'd9:    gain = 8'd144;
            5'd10:   gain = 8'd128;
            5'd11:   gain = 8'd96;
            5'd12:   gain = 8'd64;
            5'd13:   gain = 8'd48;
            5'd14:   gain = 8'd32;
            5'd15:   gain = 8'd16;
            default: gain = 8'd0;     // note has died out
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt     <= '0;
            running <= 1'b0;
            done    <= 1'b0;
        end
        else if (note == '0)
        begin
            cnt     <= '0;
            running <= 1'b0;
            done    <= 1'b0;
        end
        else if (cnt < LIMIT)
        begin
            cnt     <= cnt + 1'b1;
            running <= 1'b1;
            done    <= 1'b0;
        end
        else
        begin
            running <= 1'b0;      // hold at the limit
            done    <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        attenuated <= piano_pkg::note_t'(product >> GAIN_W);
    end

    a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(running && done));
    a_done_at_limit: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> cnt == CNT_W'(LIMIT));

endmodule

// File: source/piano.sv
// ***************************************************************************
// three-voice piano tone path, spi note frames in, serial dac samples out
// led shows running and done for each voice, voice 1 in the top bits
// ***************************************************************************
`timescale 1ns/1ns

module piano
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sck,
    input  logic       sdi,
    output logic [5:0] led,
    output logic       dclk,
    output logic       data,
    output logic       load,
    output logic       ldac
);
    piano_pkg::note_t       note1, note2, note3;
    piano_pkg::note_count_t note_count;
    piano_pkg::note_t       atten1, atten2, atten3;
    piano_pkg::note_t       mix;
    logic                   running1, running2, running3;
    logic                   done1, done2, done3;

    spi_note_receiver u_rx (.clk(clk), .rst_n(rst_n), .sck(sck), .sdi(sdi),
        .note1(note1), .note2(note2), .note3(note3), .note_count(note_count));

    note_envelope voice1 (.clk(clk), .rst_n(rst_n), .note(note1),
        .attenuated(atten1), .running(running1), .done(done1));
    note_envelope voice2 (.clk(clk), .rst_n(rst_n), .note(note2),
        .attenuated(atten2), .running(running2), .done(done2));
    note_envelope voice3 (.clk(clk), .rst_n(rst_n), .note(note3),
        .attenuated(atten3), .running(running3), .done(done3));

    voice_mixer u_mix (.voice1(atten1), .voice2(atten2), .voice3(atten3),
        .note_count(note_count), .mix(mix));

    dac_serializer u_dac (.clk(clk), .rst_n(rst_n), .sample(mix),
        .dclk(dclk), .data(data), .load(load), .ldac(ldac));

    assign led = {running1, done1, running2, done2, running3, done3};

endmodule

// File: source/piano_pkg.sv
// ***************************************************************************
// note and frame types shared by the piano tone path and its testbench
// reference by scoped name, e.g. piano_pkg::note_t
// ***************************************************************************

`include "piano_params.svh"

package piano_pkg;

    typedef logic [`NOTE_W-1:0]  note_t;        // unsigned amplitude
    typedef logic [`COUNT_W-1:0] note_count_t;  // 0 to 3 sounding notes

    // note1 sits in the lowest byte of the received word
    typedef struct packed
    {
        logic [`FRAME_W-`COUNT_W-3*`NOTE_W-1:0] pad;
        note_count_t                            count;
        note_t                                  note3;
        note_t                                  note2;
        note_t                                  note1;
    } note_frame_t;

    // shifted in as raw bits, read back as note fields
    typedef union packed
    {
        logic [`FRAME_W-1:0] raw;
        note_frame_t         fields;
    } spi_frame_u;

endpackage

// File: source/spi_note_receiver.sv
// ***************************************************************************
// receive-only spi link for note frames, sck and sdi sampled in the clk domain
// after the sync word every 32 bits latch three notes and the note count
// ***************************************************************************
`timescale 1ns/1ns
`include "piano_params.svh"

module spi_note_receiver
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sck,
    input  logic                   sdi,
    output piano_pkg::note_t       note1,
    output piano_pkg::note_t       note2,
    output piano_pkg::note_t       note3,
    output piano_pkg::note_count_t note_count
);
    localparam int CNT_W = $clog2(`FRAME_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`FRAME_W - 1);

    logic                  sck_s1, sck_s2, sck_s3;
    logic                  sdi_s1, sdi_s2;
    logic                  sck_rise;
    logic [`FRAME_W-1:0]   shifted;
    piano_pkg::spi_frame_u shift_q;
    logic                  armed;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  frame_done;   // one-cycle pulse after the last bit

    assign sck_rise = sck_s2 & ~sck_s3;
    assign shifted  = {shift_q.raw[`FRAME_W-2:0], sdi_s2};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sck_s1 <= 1'b0;
            sck_s2 <= 1'b0;
            sck_s3 <= 1'b0;
            sdi_s1 <= 1'b0;
            sdi_s2 <= 1'b0;
        end
        else
        begin
            sck_s1 <= sck;
            sck_s2 <= sck_s1;
            sck_s3 <= sck_s2;   // edge detect only
            sdi_s1 <= sdi;
            sdi_s2 <= sdi_s1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (sck_rise)
            shift_q.raw <= shifted;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            armed      <= 1'b0;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (sck_rise && !armed && shifted == `SYNC_WORD)
            begin
                armed   <= 1'b1;
                bit_cnt <= '0;  // frames line up with the sync word
            end
            else if (sck_rise && armed)
            begin
                bit_cnt    <= bit_cnt + 1'b1;
                frame_done <= (bit_cnt == LAST_BIT);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            note1      <= '0;
            note2      <= '0;
            note3      <= '0;
            note_count <= '0;
        end
        else if (frame_done)
        begin
            note1      <= shift_q.fields.note1;
            note2      <= shift_q.fields.note2;
            note3      <= shift_q.fields.note3;
            note_count <= shift_q.fields.count;
        end
    end

    // a new count always traces back to the sck edge that shifted in the last bit
    a_count_follows_edge: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(note_count) |-> $past(sck_rise, 2));

endmodule

// File: source/voice_mixer.sv
// ***************************************************************************
// sums the three shaped voices and scales the sum by the note count
// purely combinational, feeds the dac serializer
// ***************************************************************************
`timescale 1ns/1ns
`include "piano_params.svh"

module voice_mixer
(
    input  piano_pkg::note_t       voice1,
    input  piano_pkg::note_t       voice2,
    input  piano_pkg::note_t       voice3,
    input  piano_pkg::note_count_t note_count,
    output piano_pkg::note_t       mix
);
    localparam int SUM_W = `NOTE_W + 2;

    logic [SUM_W-1:0] sum;
    logic [SUM_W-1:0] third;
    logic [SUM_W-1:0] scaled;

    assign sum   = SUM_W'(voice1) + SUM_W'(voice2) + SUM_W'(voice3);
    // 1/4 + 1/16 + 1/64 + 1/256, close enough to a third
    assign third = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);

    always_comb
    begin
        case (note_count)
            2'd1:    scaled = sum;
            2'd2:    scaled = sum >> 1;
            2'd3:    scaled = third;
            default: scaled = '0;  // nothing sounding
        endcase
    end

    assign mix = scaled[`NOTE_W-1:0];   // upper bits dropped

endmodule

// File: verification/piano_model.svh
// ***************************************************************************
// cycle model of the tone path, gain table, envelope count, mix and dac frame
// included inside the testbench module, stepped once per clk edge
// ***************************************************************************
`ifndef PIANO_MODEL_SVH
`define PIANO_MODEL_SVH

piano_pkg::note_t       m_note [3];
piano_pkg::note_t       m_att [3];
int                     m_cnt [3];
logic                   m_run [3];
logic                   m_done [3];
piano_pkg::note_count_t m_count;
piano_pkg::note_frame_t pend;          // frame waiting for its update edge
int                     upd_cycle;
piano_pkg::note_t       exp_q [$];     // expected dac words, one per frame

function automatic int gain_of(input int seg);
    int table_g [16] = '{64, 128, 192, 255, 224, 208, 192, 176,
                         160, 144, 128, 96, 64, 48, 32, 16};
    if (seg >= 16)
        return 0;
    return table_g[seg];
endfunction

function automatic piano_pkg::note_t mix_rule(input int a, input int b, input int c,
                                              input int count);
    int s;
    int r;
    s = a + b + c;
    case (count)
        1:       r = s;
        2:       r = s >> 1;
        3:       r = (s >> 2) + (s >> 4) + (s >> 6) + (s >> 8);
        default: r = 0;
    endcase
    return piano_pkg::note_t'(r % 256);   // only the low byte reaches the dac
endfunction

task automatic model_step(input int c);
    int v;
    if ((c - 1) % `DAC_FRAME_CYCLES == 0)
        exp_q.push_back(mix_rule(m_att[0], m_att[1], m_att[2], m_count));
    for (v = 0; v < 3; v++)
    begin
        m_att[v] = piano_pkg::note_t'((int'(m_note[v]) *
                   gain_of(m_cnt[v] / `ENV_SEG_CYCLES)) >> 8);
        m_run[v]  = m_note[v] != 0 && m_cnt[v] < ENV_PERIOD;
        m_done[v] = m_note[v] != 0 && m_cnt[v] >= ENV_PERIOD;
        if (m_note[v] == 0)
            m_cnt[v] = 0;
        else if (m_cnt[v] < ENV_PERIOD)
            m_cnt[v] = m_cnt[v] + 1;
    end
    if (c == upd_cycle)
    begin
        m_note[0] = pend.note1;
        m_note[1] = pend.note2;
        m_note[2] = pend.note3;
        m_count   = pend.count;
        upd_cycle = -1;
    end
endtask

`endif

// File: verification/piano_tb.sv
// ***************************************************************************
// testbench for the piano tone path driven by random note frames over spi
// dac words, led flags and dac strobes are checked against a cycle model
// ***************************************************************************
`timescale 1ns/1ns
`include "piano_params.svh"

module piano_tb;
    localparam int ENV_PERIOD = `ENV_SEGS * `ENV_SEG_CYCLES;
    localparam int RUN_LIMIT  = 7 * ENV_PERIOD + ENV_PERIOD;  // tests span about 6 periods
    localparam int SCK_HALF   = 4;

    logic       clk, rst_n, sck, sdi;
    logic [5:0] led;
    logic       dclk, data, load, ldac;

    int          cyc;
    int          errors, checks, words_seen;
    logic [31:0] lfsr_state;
    logic [7:0]  dac_shift;
    int          dac_bits;

    `include "piano_model.svh"

    piano DUT (.clk(clk), .rst_n(rst_n), .sck(sck), .sdi(sdi), .led(led),
        .dclk(dclk), .data(data), .load(load), .ldac(ldac));

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        int          i;
        r = '0;
        for (i = 0; i < n; i++)
        begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b)
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic piano_pkg::note_t rand_note();
        piano_pkg::note_t n;
        n = piano_pkg::note_t'(rand_bits(8));
        return (n == 0) ? 8'd1 : n;
    endfunction

    function automatic logic [5:0] model_led();
        return {m_run[0], m_done[0], m_run[1], m_done[1], m_run[2], m_done[2]};
    endfunction

    task automatic note_error();
        errors++;
    endtask

    task automatic compare_word(input string name, input piano_pkg::note_t got,
                                input piano_pkg::note_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
            note_error();
        end
    endtask

    task automatic compare_led(input logic [5:0] got, input logic [5:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("Mismatch led: got %h expected %h at cycle %0d", got, exp, cyc);
            note_error();
        end
    endtask

    task automatic compare_pin(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
            note_error();
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #5;
    endtask

    // msb first with sdi held through the whole sck period
    task automatic send_frame(input logic [31:0] word, input logic latch);
        int i;
        for (i = 31; i >= 0; i--)
        begin
            sck = 1'b0;
            sdi = word[i];
            wait_cycles(SCK_HALF);
            sck = 1'b1;
            if (i == 0 && latch)
            begin
                pend      = word;
                upd_cycle = cyc + 4;   // two sync flops, edge detect, frame pulse
            end
            wait_cycles(SCK_HALF);
        end
        sck = 1'b0;
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "errors");
    endtask

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            cyc = cyc + 1;
            model_step(cyc);
            if (cyc > RUN_LIMIT)
            begin
                $display("run stopped at cycle %0d, tests did not finish in time", cyc);
                $display("** FAIL **");
                $finish;
            end
        end
    end

    // pins trail the frame position by one clock
    always @(negedge clk)
    begin
        int p;
        if (rst_n)
        begin
            compare_led(led, model_led());
            if (cyc == 0)
            begin
                compare_pin("dclk", dclk, 1'b0);
                compare_pin("load", load, 1'b1);
                compare_pin("ldac", ldac, 1'b1);
            end
            else
            begin
                p = (cyc - 1) % `DAC_FRAME_CYCLES;
                compare_pin("dclk", dclk, p < 64 && p % 8 < 4);
                compare_pin("load", load, !(p >= 72 && p < 80));
                compare_pin("ldac", ldac, !(p >= 84 && p < 92));
            end
        end
    end

    always @(negedge dclk)
    begin
        if (rst_n)
        begin
            dac_shift = {dac_shift[6:0], data};
            dac_bits  = dac_bits + 1;
            if (dac_bits == `NOTE_W)
            begin
                dac_bits = 0;
                words_seen++;
                if (exp_q.size() == 0)
                begin
                    $display("dac word arrived at cycle %0d with no frame latched", cyc);
                    note_error();
                end
                else
                    compare_word("dac word", dac_shift, exp_q.pop_front());
            end
        end
    end

    initial
    begin
        int               e0;
        piano_pkg::note_t n1, n2, n3;
        cyc = 0;
        errors = 0;
        checks = 0;
        words_seen = 0;
        dac_shift = '0;
        dac_bits = 0;
        lfsr_state = 32'h72ed;
        upd_cycle = -1;
        m_count = '0;
        for (int v = 0; v < 3; v++)
        begin
            m_note[v] = '0;
            m_att[v]  = '0;
            m_cnt[v]  = 0;
            m_run[v]  = 1'b0;
            m_done[v] = 1'b0;
        end
        rst_n = 1'b0;
        sck = 1'b0;
        sdi = 1'b0;
        repeat (3) @(posedge clk);
        #5 rst_n = 1'b1;

        e0 = errors;
        send_frame(rand_bits(32) | 32'h8000_0000, 1'b0);   // top bit set so never the sync word
        wait_cycles(200);
        send_frame(`SYNC_WORD, 1'b0);
        wait_cycles(100);
        end_test(1, "reset state and frame before sync", e0);

        e0 = errors;
        n1 = rand_note();
        send_frame({6'b0, 2'd1, 8'h00, 8'h00, n1}, 1'b1);
        wait_cycles(600);
        compare_led(led, 6'b10_00_00);
        end_test(2, "single note envelope", e0);

        e0 = errors;
        n2 = rand_note();
        send_frame({6'b0, 2'd2, 8'h00, n2, n1}, 1'b1);
        wait_cycles(600);
        n3 = rand_note();
        send_frame({6'b0, 2'd3, n3, n2, n1}, 1'b1);
        wait_cycles(600);
        end_test(3, "two and three note mixing", e0);

        e0 = errors;
        wait_cycles(1200);
        compare_led(led, 6'b01_01_01);
        send_frame(32'h0, 1'b1);
        wait_cycles(100);
        compare_led(led, 6'b00_00_00);
        send_frame({6'b0, 2'd1, 8'h00, 8'h00, rand_note()}, 1'b1);
        wait_cycles(300);
        compare_led(led, 6'b10_00_00);
        end_test(4, "done, clear and restart", e0);

        e0 = errors;
        wait_cycles(3 * `DAC_FRAME_CYCLES);
        end_test(5, "dac frame strobes", e0);

        wait_cycles(2 * `DAC_FRAME_CYCLES);
        $display("checks %0d, errors %0d, dac words %0d", checks, errors, words_seen);
        if (errors == 0 && words_seen > 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule
